//--- hw/bridge_pkg.sv
/* Shared widths, FIFO entry layouts and FSM encodings for the write bridge.
   WRAP bursts are carried through but replayed as INCR. */
package bridge_pkg;

  // ==================================================
  // AXI widths
  // ==================================================
  localparam int AXI_ID_W   = 4;
  localparam int AXI_ADDR_W = 32;
  localparam int AXI_DATA_W = 32;
  localparam int AXI_STRB_W = AXI_DATA_W / 8;
  localparam int AXI_LEN_W  = 4;
  localparam int AXI_RESP_W = 2;

  typedef logic [AXI_ID_W-1:0]   axi_id_t;
  typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [AXI_DATA_W-1:0] axi_data_t;
  typedef logic [AXI_STRB_W-1:0] axi_strb_t;
  typedef logic [AXI_LEN_W-1:0]  axi_len_t;   // Beats minus one.
  typedef logic [1:0]            axi_burst_t;
  typedef logic [AXI_RESP_W-1:0] axi_resp_t;

  localparam axi_burst_t BURST_FIXED = 2'd0;
  localparam axi_burst_t BURST_INCR  = 2'd1;
  localparam axi_burst_t BURST_WRAP  = 2'd2;
  localparam axi_resp_t  RESP_OKAY   = 2'd0;

  // ==================================================
  // FIFO entries
  // ==================================================
  typedef struct packed {
    axi_id_t    id;
    axi_addr_t  addr;
    axi_len_t   len;
    axi_burst_t burst;
  } adr_entry_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
    logic      last;
  } dat_entry_t;

  localparam int ADR_ENTRY_W = $bits(adr_entry_t);  // 42 bits.
  localparam int DAT_ENTRY_W = $bits(dat_entry_t);  // 37 bits.

  // Wishbone cycle type.
  typedef logic [2:0] wb_cti_t;
  localparam wb_cti_t CTI_CLASSIC = 3'd0;
  localparam wb_cti_t CTI_INCR    = 3'd2;
  localparam wb_cti_t CTI_END     = 3'd7;

  typedef enum logic [1:0] {ING_IDLE, ING_DATA, ING_RESP} ingress_state_t;
  typedef enum logic [1:0] {EGR_IDLE, EGR_WAIT, EGR_CYCLE} egress_state_t;

endpackage

//--- hw/bridge_ifs.sv
/* Queue-side links of the bridge. push_if is in the axi_clk domain, pop_if in wb_clk;
   strobes are single-cycle and only legal while full/empty is low. */

// ==================================================
// AXI side into the two FIFO write ports
// ==================================================
interface push_if;
  import bridge_pkg::*;

  logic       adr_wr;
  adr_entry_t adr_word;
  logic       adr_full;
  logic       dat_wr;
  dat_entry_t dat_word;
  logic       dat_full;

  modport ingress (
    output adr_wr, adr_word, dat_wr, dat_word,
    input  adr_full, dat_full
  );

  modport queue (
    input  adr_wr, adr_word, dat_wr, dat_word,
    output adr_full, dat_full
  );
endinterface

// ==================================================
// FIFO read ports out to the Wishbone side
// ==================================================
interface pop_if;
  import bridge_pkg::*;

  logic       adr_rd;
  adr_entry_t adr_word;   // Valid while adr_empty is low.
  logic       adr_empty;
  logic       dat_rd;
  dat_entry_t dat_word;   // Valid while dat_empty is low.
  logic       dat_empty;

  modport egress (
    output adr_rd, dat_rd,
    input  adr_word, adr_empty, dat_word, dat_empty
  );

  modport queue (
    input  adr_rd, dat_rd,
    output adr_word, adr_empty, dat_word, dat_empty
  );
endinterface

//--- hw/async_fifo.sv
/* Dual-clock FIFO, first-word fall-through. DEPTH_W must be 2 or more; writes
   while full and reads while empty are ignored. */
module async_fifo #(
  parameter int WIDTH   = 32,
  parameter int DEPTH_W = 3
) (
  input  logic             wr_clk,
  input  logic             rd_clk,
  input  logic             rst_n,
  input  logic             wr,
  input  logic [WIDTH-1:0] wdata,
  input  logic             rd,
  output logic [WIDTH-1:0] rdata,
  output logic             full,
  output logic             empty
);

  localparam int DEPTH = 1 << DEPTH_W;

  typedef logic [DEPTH_W:0] ptr_t;  // One extra wrap bit.

  logic [WIDTH-1:0] mem [DEPTH];

  ptr_t wr_bin, wr_gray, wr_bin_nxt;
  ptr_t rd_bin, rd_gray, rd_bin_nxt;
  ptr_t rd_gray_s1, rd_gray_s2;     // Read pointer seen in wr_clk.
  ptr_t wr_gray_s1, wr_gray_s2;     // Write pointer seen in rd_clk.
  logic wr_en, rd_en;

  assign wr_en = wr && !full;
  assign rd_en = rd && !empty;

  assign wr_bin_nxt = wr_bin + ptr_t'(wr_en);
  assign rd_bin_nxt = rd_bin + ptr_t'(rd_en);

  // ==================================================
  // Write domain
  // ==================================================
  always_ff @(posedge wr_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_bin     <= '0;
      wr_gray    <= '0;
      rd_gray_s1 <= '0;
      rd_gray_s2 <= '0;
    end else begin
      wr_bin     <= wr_bin_nxt;
      wr_gray    <= (wr_bin_nxt >> 1) ^ wr_bin_nxt;
      rd_gray_s1 <= rd_gray;
      rd_gray_s2 <= rd_gray_s1;
    end
  end

  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_bin[DEPTH_W-1:0]] <= wdata;
    end
  end

  // Full when the top two Gray bits differ and the rest match.
  assign full = (wr_gray == {~rd_gray_s2[DEPTH_W:DEPTH_W-1], rd_gray_s2[DEPTH_W-2:0]});

  // ==================================================
  // Read domain
  // ==================================================
  always_ff @(posedge rd_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_bin     <= '0;
      rd_gray    <= '0;
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
    end else begin
      rd_bin     <= rd_bin_nxt;
      rd_gray    <= (rd_bin_nxt >> 1) ^ rd_bin_nxt;
      wr_gray_s1 <= wr_gray;
      wr_gray_s2 <= wr_gray_s1;
    end
  end

  assign empty = (rd_gray == wr_gray_s2);
  assign rdata = mem[rd_bin[DEPTH_W-1:0]];  // Head entry, no read latency.

endmodule

//--- hw/axi_ingress.sv
/* AXI write target, one burst at a time. B is posted as OKAY once the wlast
   beat is queued; the beat count is taken from wlast, not from awlen. */
module axi_ingress (
  input  logic                   axi_clk,
  input  logic                   rst_n,
  input  logic                   enable,

  // AW channel.
  input  logic                   awvalid,
  output logic                   awready,
  input  bridge_pkg::axi_id_t    awid,
  input  bridge_pkg::axi_addr_t  awaddr,
  input  bridge_pkg::axi_len_t   awlen,
  input  bridge_pkg::axi_burst_t awburst,

  // W channel.
  input  logic                   wvalid,
  output logic                   wready,
  input  bridge_pkg::axi_data_t  wdata,
  input  bridge_pkg::axi_strb_t  wstrb,
  input  logic                   wlast,

  // B channel.
  output logic                   bvalid,
  input  logic                   bready,
  output bridge_pkg::axi_id_t    bid,
  output bridge_pkg::axi_resp_t  bresp,

  push_if.ingress                push
);

  import bridge_pkg::*;

  ingress_state_t state;
  logic           en_s1, en_s2;
  axi_id_t        id_q;

  // ==================================================
  // Enable into axi_clk
  // ==================================================
  always_ff @(posedge axi_clk or negedge rst_n) begin
    if (!rst_n) begin
      en_s1 <= 1'b0;
      en_s2 <= 1'b0;
    end else begin
      en_s1 <= enable;
      en_s2 <= en_s1;
    end
  end

  // ==================================================
  // Handshakes and FIFO pushes
  // ==================================================
  assign awready = (state == ING_IDLE) && en_s2 && !push.adr_full;
  assign wready  = (state == ING_DATA) && !push.dat_full;  // Full stalls W.

  assign push.adr_wr   = awvalid && awready;
  assign push.adr_word = '{id: awid, addr: awaddr, len: awlen, burst: awburst};

  assign push.dat_wr   = wvalid && wready;
  assign push.dat_word = '{data: wdata, strb: wstrb, last: wlast};

  assign bvalid = (state == ING_RESP);
  assign bid    = id_q;
  assign bresp  = RESP_OKAY;

  // Burst id kept for the response.
  always_ff @(posedge axi_clk) begin
    if (push.adr_wr) begin
      id_q <= awid;
    end
  end

  // ==================================================
  // Burst FSM
  // ==================================================
  always_ff @(posedge axi_clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ING_IDLE;
    end else begin
      case (state)
        ING_IDLE: begin
          if (push.adr_wr) begin
            state <= ING_DATA;
          end
        end
        ING_DATA: begin
          if (push.dat_wr && wlast) begin
            state <= ING_RESP;
          end
        end
        ING_RESP: begin
          if (bready) begin
            state <= ING_IDLE;  // Next AW only after B is taken.
          end
        end
        default: begin
          state <= ING_IDLE;
        end
      endcase
    end
  end

endmodule

//--- hw/wb_egress.sv
/* Classic Wishbone master, one write cycle per queued beat; cyc stays high
   between beats of a burst. Only IDLE checks enable, so a started burst finishes. */
module wb_egress (
  input  logic                  wb_clk,
  input  logic                  rst_n,
  input  logic                  enable,

  pop_if.egress                 pop,

  output logic                  wb_cyc,
  output logic                  wb_stb,
  output logic                  wb_we,
  output bridge_pkg::axi_addr_t wb_adr,
  output bridge_pkg::axi_data_t wb_dat_o,
  output bridge_pkg::axi_strb_t wb_sel,
  output bridge_pkg::wb_cti_t   wb_cti,
  output logic [1:0]            wb_bte,
  input  logic                  wb_ack
);

  import bridge_pkg::*;

  egress_state_t state;
  logic          en_s1, en_s2;
  axi_addr_t     beat_adr;
  axi_burst_t    burst_q;
  axi_len_t      remaining;   // Beats left after the current one.
  logic          single_q;
  logic          adr_step;

  // ==================================================
  // Enable into wb_clk
  // ==================================================
  always_ff @(posedge wb_clk or negedge rst_n) begin
    if (!rst_n) begin
      en_s1 <= 1'b0;
      en_s2 <= 1'b0;
    end else begin
      en_s1 <= enable;
      en_s2 <= en_s1;
    end
  end

  // ==================================================
  // FIFO pops
  // ==================================================
  assign pop.adr_rd = (state == EGR_IDLE) && en_s2 && !pop.adr_empty;
  assign pop.dat_rd = (state == EGR_CYCLE) && wb_ack;  // Beat retires on ack.

  // WRAP is replayed as INCR.
  assign adr_step = (burst_q == BURST_INCR) || (burst_q == BURST_WRAP);

  // Burst header and beat address.
  always_ff @(posedge wb_clk) begin
    if (pop.adr_rd) begin
      beat_adr  <= pop.adr_word.addr;
      burst_q   <= pop.adr_word.burst;
      remaining <= pop.adr_word.len;
      single_q  <= (pop.adr_word.len == '0);
    end else if (pop.dat_rd) begin
      remaining <= remaining - 1'b1;
      if (adr_step) begin
        beat_adr <= beat_adr + axi_addr_t'(AXI_STRB_W);
      end
    end
  end

  // ==================================================
  // Cycle FSM
  // ==================================================
  always_ff @(posedge wb_clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= EGR_IDLE;
    end else begin
      case (state)
        EGR_IDLE: begin
          if (pop.adr_rd) begin
            state <= EGR_WAIT;
          end
        end
        EGR_WAIT: begin
          if (!pop.dat_empty) begin
            state <= EGR_CYCLE;
          end
        end
        EGR_CYCLE: begin
          if (wb_ack) begin
            state <= pop.dat_word.last ? EGR_IDLE : EGR_WAIT;
          end
        end
        default: begin
          state <= EGR_IDLE;
        end
      endcase
    end
  end

  // ==================================================
  // Bus outputs
  // ==================================================
  assign wb_cyc   = (state != EGR_IDLE);
  assign wb_stb   = (state == EGR_CYCLE);
  assign wb_we    = (state == EGR_CYCLE);
  assign wb_adr   = beat_adr;
  assign wb_dat_o = pop.dat_word.data;  // FIFO head holds still until the pop.
  assign wb_sel   = pop.dat_word.strb;
  assign wb_bte   = 2'b00;

  always_comb begin
    if (single_q) begin
      wb_cti = CTI_CLASSIC;
    end else if (remaining == '0) begin
      wb_cti = CTI_END;
    end else begin
      wb_cti = CTI_INCR;
    end
  end

endmodule

//--- hw/axi2wb.sv
/* AXI write to Wishbone bridge across axi_clk and wb_clk. Write channels only;
   rst_n resets both domains asynchronously. */
module axi2wb #(
  parameter int ADR_DEPTH_W = 3,
  parameter int DAT_DEPTH_W = 4
) (
  input  logic                   axi_clk,
  input  logic                   wb_clk,
  input  logic                   rst_n,
  input  logic                   enable,

  input  logic                   awvalid,
  output logic                   awready,
  input  bridge_pkg::axi_id_t    awid,
  input  bridge_pkg::axi_addr_t  awaddr,
  input  bridge_pkg::axi_len_t   awlen,
  input  bridge_pkg::axi_burst_t awburst,

  input  logic                   wvalid,
  output logic                   wready,
  input  bridge_pkg::axi_data_t  wdata,
  input  bridge_pkg::axi_strb_t  wstrb,
  input  logic                   wlast,

  output logic                   bvalid,
  input  logic                   bready,
  output bridge_pkg::axi_id_t    bid,
  output bridge_pkg::axi_resp_t  bresp,

  output logic                   wb_cyc,
  output logic                   wb_stb,
  output logic                   wb_we,
  output bridge_pkg::axi_addr_t  wb_adr,
  output bridge_pkg::axi_data_t  wb_dat_o,
  output bridge_pkg::axi_strb_t  wb_sel,
  output bridge_pkg::wb_cti_t    wb_cti,
  output logic [1:0]             wb_bte,
  input  logic                   wb_ack
);

  import bridge_pkg::*;

  push_if push_i ();
  pop_if  pop_i ();

  axi_ingress ingress_i (
    .axi_clk (axi_clk),
    .rst_n   (rst_n),
    .enable  (enable),
    .awvalid (awvalid),
    .awready (awready),
    .awid    (awid),
    .awaddr  (awaddr),
    .awlen   (awlen),
    .awburst (awburst),
    .wvalid  (wvalid),
    .wready  (wready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wlast   (wlast),
    .bvalid  (bvalid),
    .bready  (bready),
    .bid     (bid),
    .bresp   (bresp),
    .push    (push_i.ingress)
  );

  // ==================================================
  // Clock crossing, one FIFO per entry kind
  // ==================================================
  async_fifo #(
    .WIDTH   (ADR_ENTRY_W),
    .DEPTH_W (ADR_DEPTH_W)
  ) adr_fifo_i (
    .wr_clk (axi_clk),
    .rd_clk (wb_clk),
    .rst_n  (rst_n),
    .wr     (push_i.adr_wr),
    .wdata  (push_i.adr_word),
    .rd     (pop_i.adr_rd),
    .rdata  (pop_i.adr_word),
    .full   (push_i.adr_full),
    .empty  (pop_i.adr_empty)
  );

  async_fifo #(
    .WIDTH   (DAT_ENTRY_W),
    .DEPTH_W (DAT_DEPTH_W)
  ) dat_fifo_i (
    .wr_clk (axi_clk),
    .rd_clk (wb_clk),
    .rst_n  (rst_n),
    .wr     (push_i.dat_wr),
    .wdata  (push_i.dat_word),
    .rd     (pop_i.dat_rd),
    .rdata  (pop_i.dat_word),
    .full   (push_i.dat_full),
    .empty  (pop_i.dat_empty)
  );

  wb_egress egress_i (
    .wb_clk   (wb_clk),
    .rst_n    (rst_n),
    .enable   (enable),
    .pop      (pop_i.egress),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_o (wb_dat_o),
    .wb_sel   (wb_sel),
    .wb_cti   (wb_cti),
    .wb_bte   (wb_bte),
    .wb_ack   (wb_ack)
  );

endmodule

//--- test/tb_axi2wb.sv
/* Directed tests for the AXI write to Wishbone bridge. The Wishbone model
   acks after 0 to 3 wb_clk cycles and keeps 256 words. */
module tb_axi2wb;
  import bridge_pkg::*;

  localparam int MAX_WAIT = 400;

  typedef struct packed {
    axi_addr_t adr;
    axi_data_t dat;
    axi_strb_t sel;
    wb_cti_t   cti;
  } wb_rec_t;

  logic       axi_clk, wb_clk, rst_n, enable;
  logic       awvalid, awready, wvalid, wready, wlast, bvalid, bready;
  axi_id_t    awid, bid;
  axi_addr_t  awaddr, wb_adr;
  axi_len_t   awlen;
  axi_burst_t awburst;
  axi_data_t  wdata, wb_dat_o;
  axi_strb_t  wstrb, wb_sel;
  axi_resp_t  bresp;
  logic       wb_cyc, wb_stb, wb_we, wb_ack;
  wb_cti_t    wb_cti;
  logic [1:0] wb_bte;

  wb_rec_t    wb_log [$];
  axi_data_t  mem [256];
  axi_data_t  beat_data [16];
  axi_strb_t  beat_strb [16];
  int         errors, test_count, failed_tests, b_count;
  logic       stall_seen;

  axi2wb dut_i (
    .axi_clk (axi_clk), .wb_clk (wb_clk), .rst_n (rst_n), .enable (enable),
    .awvalid (awvalid), .awready (awready), .awid (awid), .awaddr (awaddr),
    .awlen (awlen), .awburst (awburst),
    .wvalid (wvalid), .wready (wready), .wdata (wdata), .wstrb (wstrb), .wlast (wlast),
    .bvalid (bvalid), .bready (bready), .bid (bid), .bresp (bresp),
    .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
    .wb_dat_o (wb_dat_o), .wb_sel (wb_sel), .wb_cti (wb_cti), .wb_bte (wb_bte),
    .wb_ack (wb_ack)
  );

  initial begin
    axi_clk = 1'b0;
    forever #2 axi_clk = ~axi_clk;
  end

  initial begin
    wb_clk = 1'b0;
    #1;  // Domains out of phase.
    forever #2 wb_clk = ~wb_clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic wb_cti_t expected_cti(input axi_len_t len, input int i);
    if (len == 4'd0) return 3'd0;
    return (i == int'(len)) ? 3'd7 : 3'd2;
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %0h, expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic timeout_error(input string what);
    $display("Timeout at %0t: no %s within %0d cycles", $time, what, MAX_WAIT);
    errors++;
  endtask

  // ==================================================
  // Wishbone memory model and B monitor
  // ==================================================
  task automatic store_beat();
    wb_rec_t rec;
    int idx;
    idx = int'(wb_adr[9:2]);
    for (int b = 0; b < AXI_STRB_W; b++) begin
      if (wb_sel[b]) mem[idx][8*b +: 8] = wb_dat_o[8*b +: 8];
    end
    rec = '{adr: wb_adr, dat: wb_dat_o, sel: wb_sel, cti: wb_cti};
    wb_log.push_back(rec);
  endtask

  initial begin
    logic [31:0] rng;
    int wait_left;
    logic busy;
    wb_ack = 1'b0;
    rng = 32'd19016;
    busy = 1'b0;
    wait_left = 0;
    for (int i = 0; i < 256; i++) mem[i] = '0;
    forever begin
      @(posedge wb_clk);
      if (wb_ack) begin
        wb_ack <= 1'b0;
      end else if (wb_cyc && wb_stb) begin
        if (!busy) begin
          rng = xorshift32(rng);
          wait_left = int'(rng[1:0]);  // Ack delay for this cycle.
          busy = 1'b1;
        end
        if (wait_left == 0) begin
          check("wb_we", wb_we, 1'b1);
          check("wb_bte", wb_bte, 2'b00);
          store_beat();
          wb_ack <= 1'b1;
          busy = 1'b0;
        end else begin
          wait_left--;
        end
      end
    end
  end

  initial begin
    b_count = 0;
    forever begin
      @(posedge axi_clk);
      if (bvalid && bready) b_count++;
    end
  end

  // ==================================================
  // AXI driver
  // ==================================================
  task automatic axi_write(input axi_id_t id, input axi_addr_t addr, input axi_len_t len,
                           input axi_burst_t burst, input int b_hold);
    int n;
    logic done;
    awvalid <= 1'b1;
    awid    <= id;
    awaddr  <= addr;
    awlen   <= len;
    awburst <= burst;
    done = 1'b0;
    n = 0;
    while (!done && n < MAX_WAIT) begin
      @(posedge axi_clk);
      check("bvalid", bvalid, 1'b0);
      done = (awready === 1'b1);
      n++;
    end
    awvalid <= 1'b0;
    if (!done) begin
      timeout_error("AW handshake");
      return;
    end
    for (int i = 0; i <= int'(len); i++) begin
      wvalid <= 1'b1;
      wdata  <= beat_data[i];
      wstrb  <= beat_strb[i];
      wlast  <= (i == int'(len));
      done = 1'b0;
      n = 0;
      while (!done && n < MAX_WAIT) begin
        @(posedge axi_clk);
        check("bvalid", bvalid, 1'b0);  // No B before the wlast handshake.
        done = (wready === 1'b1);
        if (!done) stall_seen = 1'b1;
        n++;
      end
      if (!done) begin
        wvalid <= 1'b0;
        timeout_error("W handshake");
        return;
      end
    end
    wvalid <= 1'b0;
    wlast  <= 1'b0;
    for (int c = 0; c < b_hold; c++) begin
      @(posedge axi_clk);
      check("bvalid", bvalid, 1'b1);
      check("awready", awready, 1'b0);
    end
    bready <= 1'b1;
    done = 1'b0;
    n = 0;
    while (!done && n < MAX_WAIT) begin
      @(posedge axi_clk);
      done = (bvalid === 1'b1);
      n++;
    end
    bready <= 1'b0;
    if (!done) begin
      timeout_error("B response");
      return;
    end
    check("bid", bid, id);
    check("bresp", bresp, 2'd0);
  endtask

  task automatic fill_beats(input int k);
    for (int i = 0; i < 16; i++) begin
      beat_data[i] = axi_data_t'(32'hB000_0000 + (k << 8) + i);
      beat_strb[i] = 4'hF;
    end
  endtask

  task automatic wait_beats(input int count);
    int n;
    n = 0;
    while (wb_log.size() < count && n < MAX_WAIT * 4) begin
      @(posedge axi_clk);
      n++;
    end
    if (wb_log.size() < count) timeout_error("Wishbone beats");
    repeat (8) @(posedge axi_clk);
    check("beat count", wb_log.size(), count);
  endtask

  task automatic check_burst(input int first, input axi_addr_t base, input axi_len_t len,
                             input axi_burst_t burst);
    wb_rec_t rec;
    axi_addr_t exp_adr;
    for (int i = 0; i <= int'(len); i++) begin
      if (first + i >= wb_log.size()) begin
        $display("Beat %0d of the burst at %0h never reached the Wishbone bus", i, base);
        errors++;
        return;
      end
      rec = wb_log[first + i];
      exp_adr = (burst == 2'd0) ? base : base + axi_addr_t'(4 * i);  // FIXED holds.
      check("wb_adr", rec.adr, exp_adr);
      check("wb_dat_o", rec.dat, beat_data[i]);
      check("wb_sel", rec.sel, beat_strb[i]);
      check("wb_cti", rec.cti, expected_cti(len, i));
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    test_count++;
    if (errors != err_before) failed_tests++;
    $display("[%0t] %s %s", $time, name, (errors == err_before) ? "pass" : "fail");
  endtask

  // ==================================================
  // Directed tests
  // ==================================================
  task automatic single_beat();
    int e0 = errors;
    int b0 = b_count;
    wb_log.delete();
    beat_data[0] = 32'h1234_5678;
    beat_strb[0] = 4'b0110;
    axi_write(4'h3, 32'h40, 4'd0, 2'd1, 0);
    wait_beats(1);
    check_burst(0, 32'h40, 4'd0, 2'd1);
    check("mem[16]", mem[16], 32'h0034_5600);  // Only lanes 1 and 2 written.
    check("B count", b_count - b0, 1);
    finish_test("single_beat", e0);
  endtask

  task automatic incr_burst();
    int e0 = errors;
    wb_log.delete();
    fill_beats(1);
    axi_write(4'h1, 32'h20, 4'd3, 2'd1, 0);
    wait_beats(4);
    check_burst(0, 32'h20, 4'd3, 2'd1);
    finish_test("incr_burst", e0);
  endtask

  task automatic fixed_burst();
    int e0 = errors;
    wb_log.delete();
    fill_beats(2);
    axi_write(4'h2, 32'h60, 4'd2, 2'd0, 0);
    wait_beats(3);
    check_burst(0, 32'h60, 4'd2, 2'd0);
    check("mem[24]", mem[24], beat_data[2]);  // Last beat wins.
    finish_test("fixed_burst", e0);
  endtask

  task automatic write_response();
    int e0 = errors;
    int b0 = b_count;
    wb_log.delete();
    fill_beats(3);
    axi_write(4'h9, 32'h300, 4'd1, 2'd1, 10);
    wait_beats(2);
    check_burst(0, 32'h300, 4'd1, 2'd1);
    check("B count", b_count - b0, 1);
    finish_test("write_response", e0);
  endtask

  task automatic enable_gate();
    int e0 = errors;
    int n = 0;
    logic hit = 1'b0;
    wb_log.delete();
    fill_beats(4);
    // Enable drops at the AW handshake, so the burst sits in the FIFOs.
    fork
      axi_write(4'h5, 32'h80, 4'd0, 2'd1, 0);
      begin
        while (!hit && n < MAX_WAIT) begin
          @(posedge axi_clk);
          hit = awvalid && awready;
          n++;
        end
        if (!hit) timeout_error("AW handshake");
        enable <= 1'b0;
      end
    join
    for (int c = 0; c < 40; c++) begin
      @(posedge axi_clk);
      check("awready", awready, 1'b0);
      check("wb_cyc", wb_cyc, 1'b0);
    end
    enable <= 1'b1;
    wait_beats(1);
    check_burst(0, 32'h80, 4'd0, 2'd1);
    finish_test("enable_gate", e0);
  endtask

  task automatic back_pressure();
    int e0 = errors;
    int b0 = b_count;
    stall_seen = 1'b0;
    wb_log.delete();
    for (int k = 0; k < 12; k++) begin
      fill_beats(k);
      axi_write(axi_id_t'(k), axi_addr_t'(32'h100 + 16 * k), 4'd3, 2'd1, 0);
    end
    wait_beats(48);
    for (int k = 0; k < 12; k++) begin
      fill_beats(k);
      check_burst(4 * k, axi_addr_t'(32'h100 + 16 * k), 4'd3, 2'd1);
    end
    check("B count", b_count - b0, 12);
    check("wready stall seen", stall_seen, 1'b1);
    finish_test("back_pressure", e0);
  endtask

  initial begin
    errors = 0;
    test_count = 0;
    failed_tests = 0;
    stall_seen = 1'b0;
    rst_n = 1'b0;
    enable = 1'b1;
    awvalid = 1'b0;
    awid = '0;
    awaddr = '0;
    awlen = '0;
    awburst = '0;
    wvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wlast = 1'b0;
    bready = 1'b0;
    repeat (8) @(posedge axi_clk);
    rst_n <= 1'b1;
    repeat (4) @(posedge axi_clk);  // Enable through both synchronizers.
    single_beat();
    incr_burst();
    fixed_burst();
    write_response();
    enable_gate();
    back_pressure();
    $display("%0d tests run, %0d failed, %0d errors", test_count, failed_tests, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- files.f
hw/bridge_pkg.sv
hw/bridge_ifs.sv
hw/async_fifo.sv
hw/axi_ingress.sv
hw/wb_egress.sv
hw/axi2wb.sv
test/tb_axi2wb.sv

//--- Makefile
TOP = tb_axi2wb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, scan $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   list these targets"

test:
	verilator --binary --timing -Wno-fatal -f files.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" $(LOG) || (echo "No result in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
